/* compile.f */
verilog/scene_pkg.sv
verilog/vga_timing.sv
verilog/draw_goal_bg.sv
verilog/draw_ball.sv
verilog/scene_regs.sv
verilog/goal_scene_top.sv
verification/goal_scene_checker.sv
verification/tb_clock.sv
verification/goal_scene_tb.sv

/* Makefile */
TOP := goal_scene_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -Wall -Wno-fatal -f compile.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; \
	echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir

/* verification/goal_scene_tb.sv */
// goal_scene_tb: AXI driver, pixel reference model, comparing process, sync checks, timeout
`timescale 1ns/1ns

module goal_scene_tb;

  import scene_pkg::*;

  localparam int H_ACTIVE = 800;
  localparam int V_ACTIVE = 600;
  localparam int H_SYNC   = 128;
  localparam int V_SYNC   = 4;
  localparam int H_TOTAL  = 1056;
  localparam int V_TOTAL  = 628;
  // four frames of tests plus margin
  localparam int LIMIT    = 4 * H_TOTAL * V_TOTAL + 10000;

  logic      clk;
  logic      rst;
  axil_req_t req;
  axil_rsp_t rsp;
  vid_t      vid;
  ball_cfg_t tb_live;
  ball_cfg_t exp_ball;
  int        errors = 0;
  int        printed = 0;
  int        frame_no = 0;
  int        cycles = 0;
  int        hs_run = 0;
  int        vs_run = 0;
  int        hs_seen = 0;
  int        vs_seen = 0;
  int        tests_run = 0;
  int        nxt_h = 0;
  int        nxt_v = 0;
  logic      exp_hblnk;
  logic      exp_vblnk;
  logic      armed = 1'b0;
  logic      prev_hs = 1'b0;
  logic      prev_vs = 1'b0;
  string     cur_test = "reset";

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  goal_scene_top dut (
    .clk      (clk),
    .rst      (rst),
    .axil_req (req),
    .axil_rsp (rsp),
    .vid      (vid)
  );

  // expected colour of one output pixel
  function automatic rgb_t ref_pixel(input logic [10:0] h, input logic [10:0] v,
                                     input logic blank, input ball_cfg_t b);
    int hi;
    int vi;
    int dx;
    int dy;
    hi = int'(h);
    vi = int'(v);
    dx = (hi > H_ACTIVE / 2) ? hi - H_ACTIVE / 2 : H_ACTIVE / 2 - hi;
    dy = (vi > 450) ? vi - 450 : 450 - vi;
    if (blank) return '0;
    if (b.enable && hi >= int'(b.x) && hi < int'(b.x) + 16 &&
        vi >= int'(b.y) && vi < int'(b.y) + 16) return b.colour;
    if (hi >= 150 && hi < H_ACTIVE - 150 && vi >= 200 && vi < 400 &&
        !(hi >= 162 && hi < H_ACTIVE - 162 && vi >= 212)) return GREY_GOALPOST;
    if (vi < 200 && hi >= 150 && hi < H_ACTIVE - 150 && (hi - 150) % 20 == 0)
      return WHITE_NET;
    if ((vi >= 394 && vi < 400) || (vi >= 330 && vi <= 332) || (dx <= 10 && dy <= 6))
      return WHITE_LINES;
    if (vi > 300) return GREEN_GRASS;
    return BLUE_BG;
  endfunction

  task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
    if (exp !== act) begin
      errors++;
      if (printed < 20) begin
        $display("[ERROR] %s expected %h actual %h at (%0d,%0d)", name, exp, act,
                 vid.hcount, vid.vcount);
        printed++;
      end
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_vid(input string name, input vid_t exp, input vid_t act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("[ERROR] %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic report(input string name, input int start_errors);
    tests_run++;
    if (errors == start_errors) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errors - start_errors);
    end
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    int d;
    d = $urandom % 4;
    @(posedge clk);
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    @(posedge clk);
    while (!(rsp.awready && rsp.wready)) @(posedge clk);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    // register map as seen by the host
    case (addr)
      4'h0: begin
        tb_live.x = data[10:0];
        tb_live.y = data[26:16];
      end
      4'h4: tb_live.colour = data[11:0];
      4'h8: tb_live.enable = data[0];
      default: ;
    endcase
    repeat (d) @(posedge clk);
    req.bready <= 1'b1;
    @(posedge clk);
    while (!rsp.bvalid) @(posedge clk);
    resp = rsp.bresp;
    req.bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int d;
    d = $urandom % 4;
    @(posedge clk);
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    @(posedge clk);
    while (!rsp.arready) @(posedge clk);
    req.arvalid <= 1'b0;
    repeat (d) @(posedge clk);
    req.rready <= 1'b1;
    @(posedge clk);
    while (!rsp.rvalid) @(posedge clk);
    data = rsp.rdata;
    resp = rsp.rresp;
    req.rready <= 1'b0;
  endtask

  task automatic write_read(input string name, input logic [3:0] addr,
                            input logic [31:0] data, input logic [31:0] exp);
    logic [1:0]  resp;
    logic [31:0] rd;
    axi_write(addr, data, resp);
    check_resp({name, "_bresp"}, 2'b00, resp);
    axi_read(addr, rd, resp);
    check_resp({name, "_rresp"}, 2'b00, resp);
    check_word(name, exp, rd);
  endtask

  task automatic wait_frame();
    int f;
    f = frame_no;
    while (frame_no == f) @(posedge clk);
  endtask

  task automatic wait_line(input int v);
    while (!(int'(vid.vcount) == v && vid.hcount == '0)) @(posedge clk);
  endtask

  // output comparison and sync width measurement
  always @(posedge clk) begin
    if (!rst) begin
      if (vid.hcount != '0) armed = 1'b1;
      if (armed && vid.hcount == '0 && vid.vcount == '0) begin
        exp_ball = tb_live;
        frame_no++;
      end
      if (frame_no >= 1) begin
        check_word("hcount", nxt_h, vid.hcount);
        check_word("vcount", nxt_v, vid.vcount);
        exp_hblnk = (int'(vid.hcount) >= H_ACTIVE);
        exp_vblnk = (int'(vid.vcount) >= V_ACTIVE);
        check_bit("hblnk", exp_hblnk, vid.hblnk);
        check_bit("vblnk", exp_vblnk, vid.vblnk);
        check_rgb(cur_test, ref_pixel(vid.hcount, vid.vcount, exp_hblnk || exp_vblnk,
                  exp_ball), vid.rgb);
      end
      // raster position expected on the next cycle
      if (int'(vid.hcount) == H_TOTAL - 1) begin
        nxt_h = 0;
        nxt_v = (int'(vid.vcount) == V_TOTAL - 1) ? 0 : int'(vid.vcount) + 1;
      end else begin
        nxt_h = int'(vid.hcount) + 1;
        nxt_v = int'(vid.vcount);
      end
      if (vid.hsync) hs_run++;
      if (prev_hs && !vid.hsync) begin
        hs_seen++;
        check_word("hsync_width", H_SYNC, hs_run);
        hs_run = 0;
      end
      if (vid.vsync) vs_run++;
      if (prev_vs && !vid.vsync) begin
        vs_seen++;
        check_word("vsync_width", V_SYNC * H_TOTAL, vs_run);
        vs_run = 0;
      end
      prev_hs = vid.hsync;
      prev_vs = vid.vsync;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Testbench failed");
      $finish;
    end
  end

  initial begin
    int          e;
    logic [10:0] bx;
    logic [10:0] by;
    logic [1:0]  resp;
    logic [31:0] rd;
    logic [31:0] word;
    req     = '0;
    tb_live = '0;
    exp_ball = '0;
    void'($urandom(74184));

    // 1: reset state
    @(negedge rst);
    e = errors;
    check_vid("reset_vid", '0, vid);
    check_bit("reset_awready", 1'b0, rsp.awready);
    check_bit("reset_wready", 1'b0, rsp.wready);
    check_bit("reset_bvalid", 1'b0, rsp.bvalid);
    check_bit("reset_arready", 1'b0, rsp.arready);
    check_bit("reset_rvalid", 1'b0, rsp.rvalid);
    report("reset_state", e);

    // 2: register access, ball left disabled
    e = errors;
    // x in bits 10:0 and y in bits 26:16, the rest reads zero
    word = $urandom;
    write_read("reg_pos_masked", 4'h0, word, word & 32'h07FF_07FF);
    bx = 11'($urandom % 2048);
    by = 11'($urandom % 2048);
    write_read("reg_pos", 4'h0, {5'b0, by, 5'b0, bx}, {5'b0, by, 5'b0, bx});
    write_read("reg_color", 4'h4, 32'h0000_0A5C, 32'h0000_0A5C);
    write_read("reg_ctrl_on", 4'h8, 32'h1, 32'h1);
    write_read("reg_ctrl_off", 4'h8, 32'h0, 32'h0);
    axi_read(4'hC, rd, resp);
    check_resp("unmapped_rresp", 2'b00, resp);
    check_word("unmapped_read", 32'h0, rd);
    report("register_access", e);

    // 3: full frame without ball, next frame setup written mid-frame
    cur_test = "frame_no_ball";
    e = errors;
    wait_frame();
    wait_line(100);
    // ball wholly above line 300
    bx = 11'($urandom % (H_ACTIVE - 15));
    by = 11'($urandom % 284);
    axi_write(4'h0, {5'b0, by, 5'b0, bx}, resp);
    axi_write(4'h4, {20'b0, 12'($urandom)}, resp);
    axi_write(4'h8, 32'h1, resp);
    wait_frame();
    report("frame_no_ball", e);

    // 4: ball frame, move written at line 300
    cur_test = "frame_ball";
    e = errors;
    wait_line(300);
    report("frame_ball", e);
    cur_test = "ball_move";
    e = errors;
    // new position lies in the part of the frame still to come
    bx = 11'((int'(bx) + 200) % (H_ACTIVE - 15));
    by = 11'(320 + $urandom % (V_ACTIVE - 15 - 320));
    axi_write(4'h0, {5'b0, by, 5'b0, bx}, resp);
    wait_frame();
    wait_frame();
    report("ball_move", e);

    // 6: sync widths checked all along by the comparing process
    e = errors;
    if (hs_seen == 0 || vs_seen == 0) begin
      errors++;
      $display("sync pulses missing at the output");
    end
    report("sync_widths", e);

    $display("tests run %0d, errors %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* verification/tb_clock.sv */
// tb_clock: testbench clock and synchronous reset generator
`timescale 1ns/1ns

module tb_clock #(
  parameter int HALF_PERIOD  = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

/* verification/goal_scene_checker.sv */
// goal_scene_checker: AXI4-Lite handshake assertions, bound into scene_regs
`timescale 1ns/1ns

module goal_scene_checker (
  input logic                 clk,
  input logic                 rst,
  input scene_pkg::axil_req_t axil_req,
  input scene_pkg::axil_rsp_t axil_rsp
);

  // no new write beat while a response waits
  awready_vs_bvalid: assert property (@(posedge clk) disable iff (rst)
    !(axil_rsp.awready && axil_rsp.bvalid))
    else $error("awready high while bvalid is pending");

  wready_vs_bvalid: assert property (@(posedge clk) disable iff (rst)
    !(axil_rsp.wready && axil_rsp.bvalid))
    else $error("wready high while bvalid is pending");

  bvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (axil_rsp.bvalid && !axil_req.bready) |=> axil_rsp.bvalid)
    else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge clk) disable iff (rst)
    (axil_rsp.rvalid && !axil_req.rready) |=> axil_rsp.rvalid)
    else $error("rvalid dropped before rready");

endmodule

bind scene_regs goal_scene_checker u_checker (
  .clk      (clk),
  .rst      (rst),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp)
);

/* verilog/goal_scene_top.sv */
// goal_scene_top: register slave beside the timing, background and ball stages
`timescale 1ns/1ns

module goal_scene_top #(
  parameter int H_ACTIVE = 800,
  parameter int H_FP     = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BP     = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FP     = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BP     = 23
) (
  input  logic                 clk,
  input  logic                 rst,
  input  scene_pkg::axil_req_t axil_req,
  output scene_pkg::axil_rsp_t axil_rsp,
  output scene_pkg::vid_t      vid
);

  import scene_pkg::*;

  vid_t      vid_timing;
  vid_t      vid_bg;
  logic      frame_start;
  ball_cfg_t ball_cfg;

  scene_regs u_scene_regs (
    .clk         (clk),
    .rst         (rst),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .frame_start (frame_start),
    .ball        (ball_cfg)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) u_vga_timing (
    .clk         (clk),
    .rst         (rst),
    .vid         (vid_timing),
    .frame_start (frame_start)
  );

  draw_goal_bg #(
    .H_ACTIVE (H_ACTIVE)
  ) u_draw_goal_bg (
    .clk     (clk),
    .rst     (rst),
    .vid_in  (vid_timing),
    .vid_out (vid_bg)
  );

  draw_ball u_draw_ball (
    .clk     (clk),
    .rst     (rst),
    .vid_in  (vid_bg),
    .ball    (ball_cfg),
    .vid_out (vid)
  );

endmodule

/* verilog/scene_regs.sv */
// scene_regs: AXI4-Lite slave with ball position, colour and enable, shadowed per frame
`timescale 1ns/1ns

module scene_regs (
  input  logic                 clk,
  input  logic                 rst,
  input  scene_pkg::axil_req_t axil_req,
  output scene_pkg::axil_rsp_t axil_rsp,
  input  logic                 frame_start,
  output scene_pkg::ball_cfg_t ball
);

  import scene_pkg::*;

  ball_cfg_t   live;
  logic        wr_ready;
  logic        bvalid;
  logic        ar_ready;
  logic        rvalid;
  logic [31:0] rdata;
  logic [31:0] rd_word;
  logic        wr_fire;
  logic        rd_fire;

  // AW and W are taken together in one beat
  assign wr_fire = wr_ready && axil_req.awvalid && axil_req.wvalid;
  assign rd_fire = ar_ready && axil_req.arvalid;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ready <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      // one-cycle ready pulse, held off while a response is pending
      wr_ready <= axil_req.awvalid && axil_req.wvalid && !bvalid && !wr_ready;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bvalid && axil_req.bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // live registers, strobes not supported
  always_ff @(posedge clk) begin
    if (rst) begin
      live <= '0;
    end else if (wr_fire) begin
      case (axil_req.awaddr)
        REG_POS: begin
          live.x <= axil_req.wdata[10:0];
          live.y <= axil_req.wdata[26:16];
        end
        REG_COLOR: live.colour <= axil_req.wdata[11:0];
        REG_CTRL:  live.enable <= axil_req.wdata[0];
        default: ;
      endcase
    end
  end

  // read mux on live values
  always_comb begin
    case (axil_req.araddr)
      REG_POS:   rd_word = {5'b0, live.y, 5'b0, live.x};
      REG_COLOR: rd_word = {20'b0, live.colour};
      REG_CTRL:  rd_word = {31'b0, live.enable};
      default:   rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ar_ready <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      ar_ready <= axil_req.arvalid && !rvalid && !ar_ready;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rvalid && axil_req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
    end
  end

  // shadow copy, picked up by the video path from pixel (0,0) on
  always_ff @(posedge clk) begin
    if (rst) begin
      ball <= '0;
    end else if (frame_start) begin
      ball <= live;
    end
  end

  always_comb begin
    axil_rsp.awready = wr_ready;
    axil_rsp.wready  = wr_ready;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = AXI_RESP_OKAY;
    axil_rsp.arready = ar_ready;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = AXI_RESP_OKAY;
  end

endmodule

/* verilog/draw_ball.sv */
// draw_ball: square ball overlay and blanking of colour outside the active area
`timescale 1ns/1ns

module draw_ball (
  input  logic                 clk,
  input  logic                 rst,
  input  scene_pkg::vid_t      vid_in,
  input  scene_pkg::ball_cfg_t ball,
  output scene_pkg::vid_t      vid_out
);

  import scene_pkg::*;

  // one extra bit so a ball near the right or bottom edge does not wrap
  logic [11:0] x_end;
  logic [11:0] y_end;
  logic        in_x;
  logic        in_y;
  logic        hit;
  logic        blank;
  rgb_t        rgb_nxt;

  assign x_end = {1'b0, ball.x} + {1'b0, BALL_SIZE};
  assign y_end = {1'b0, ball.y} + {1'b0, BALL_SIZE};

  assign in_x  = (vid_in.hcount >= ball.x) && ({1'b0, vid_in.hcount} < x_end);
  assign in_y  = (vid_in.vcount >= ball.y) && ({1'b0, vid_in.vcount} < y_end);
  assign hit   = ball.enable && in_x && in_y;

  assign blank = vid_in.hblnk || vid_in.vblnk;

  always_comb begin
    if (blank) begin
      rgb_nxt = '0;
    end else if (hit) begin
      rgb_nxt = ball.colour;
    end else begin
      rgb_nxt = vid_in.rgb;
    end
  end

  // coordinates and syncs stay aligned with the colour
  always_ff @(posedge clk) begin
    if (rst) begin
      vid_out <= '0;
    end else begin
      vid_out.hcount <= vid_in.hcount;
      vid_out.vcount <= vid_in.vcount;
      vid_out.hsync  <= vid_in.hsync;
      vid_out.vsync  <= vid_in.vsync;
      vid_out.hblnk  <= vid_in.hblnk;
      vid_out.vblnk  <= vid_in.vblnk;
      vid_out.rgb    <= rgb_nxt;
    end
  end

endmodule

/* verilog/draw_goal_bg.sv */
// draw_goal_bg: goal, net, pitch lines, grass and sky painted from pixel coordinates
`timescale 1ns/1ns

module draw_goal_bg #(
  parameter int H_ACTIVE = 800
) (
  input  logic            clk,
  input  logic            rst,
  input  scene_pkg::vid_t vid_in,
  output scene_pkg::vid_t vid_out
);

  import scene_pkg::*;

  localparam logic [10:0] HOR_PIXELS = 11'(H_ACTIVE);

  // goal frame, right side mirrored about the screen centre
  localparam logic [10:0] POST_RIGHT_EDGE    = HOR_PIXELS - GK_POST_OUTER_EDGE;
  localparam logic [10:0] OPENING_RIGHT_EDGE = HOR_PIXELS - GK_POST_INNER_EDGE;

  // line bands
  localparam logic [10:0] GOAL_LINE_TOP  = GK_POST_BOTTOM_EDGE - 11'd6;
  localparam logic [10:0] SIX_YARD_END   = GK_SIX_YARD_LINE + 11'd3;

  // penalty spot box around the screen centre
  localparam logic [10:0] SPOT_X     = HOR_PIXELS / 11'd2;
  localparam logic [10:0] SPOT_X_MIN = SPOT_X - 11'd10;
  localparam logic [10:0] SPOT_X_MAX = SPOT_X + 11'd10;
  localparam logic [10:0] SPOT_Y_MIN = PENALTY_SPOT_Y - 11'd6;
  localparam logic [10:0] SPOT_Y_MAX = PENALTY_SPOT_Y + 11'd6;

  logic [10:0] hc;
  logic [10:0] vc;
  logic [10:0] net_offset;
  logic        in_goal_box;
  logic        in_opening;
  logic        on_post;
  logic        on_net;
  logic        on_line;
  logic        on_spot;
  rgb_t        rgb_nxt;

  assign hc = vid_in.hcount;
  assign vc = vid_in.vcount;

  // distance from the left post, one strand every GK_NET_WIDTH pixels
  assign net_offset = hc - GK_POST_OUTER_EDGE;

  always_comb begin
    in_goal_box = (hc >= GK_POST_OUTER_EDGE) && (hc < POST_RIGHT_EDGE) &&
                  (vc >= GK_POST_TOP_EDGE) && (vc < GK_POST_BOTTOM_EDGE);
    in_opening  = (hc >= GK_POST_INNER_EDGE) && (hc < OPENING_RIGHT_EDGE) &&
                  (vc >= GK_CROSSBAR_BOTTOM_EDGE) && (vc < GK_POST_BOTTOM_EDGE);
    on_post     = in_goal_box && !in_opening;

    // vertical strands only, above the crossbar
    on_net      = (vc < GK_POST_TOP_EDGE) &&
                  (hc >= GK_POST_OUTER_EDGE) && (hc < POST_RIGHT_EDGE) &&
                  ((net_offset % GK_NET_WIDTH) == '0);

    on_spot     = (hc >= SPOT_X_MIN) && (hc <= SPOT_X_MAX) &&
                  (vc >= SPOT_Y_MIN) && (vc <= SPOT_Y_MAX);
    on_line     = ((vc >= GOAL_LINE_TOP) && (vc < GK_POST_BOTTOM_EDGE)) ||
                  ((vc >= GK_SIX_YARD_LINE) && (vc < SIX_YARD_END)) ||
                  on_spot;
  end

  // first match wins
  always_comb begin
    if (on_post) begin
      rgb_nxt = GREY_GOALPOST;
    end else if (on_net) begin
      rgb_nxt = WHITE_NET;
    end else if (on_line) begin
      rgb_nxt = WHITE_LINES;
    end else if (vc > GK_GRASS_HEIGHT) begin
      rgb_nxt = GREEN_GRASS;
    end else begin
      rgb_nxt = BLUE_BG;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vid_out <= '0;
    end else begin
      vid_out     <= vid_in;
      vid_out.rgb <= rgb_nxt;
    end
  end

endmodule

/* verilog/vga_timing.sv */
// vga_timing: raster counters, sync and blanking, frame start pulse
`timescale 1ns/1ns

module vga_timing #(
  parameter int H_ACTIVE = 800,
  parameter int H_FP     = 40,
  parameter int H_SYNC   = 128,
  parameter int H_BP     = 88,
  parameter int V_ACTIVE = 600,
  parameter int V_FP     = 1,
  parameter int V_SYNC   = 4,
  parameter int V_BP     = 23
) (
  input  logic            clk,
  input  logic            rst,
  output scene_pkg::vid_t vid,
  output logic            frame_start
);

  import scene_pkg::*;

  localparam int H_SYNC_START = H_ACTIVE + H_FP;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int H_TOTAL      = H_SYNC_END + H_BP;
  localparam int V_SYNC_START = V_ACTIVE + V_FP;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;
  localparam int V_TOTAL      = V_SYNC_END + V_BP;

  logic [10:0] hc_nxt;
  logic [10:0] vc_nxt;

  // next raster position
  always_comb begin
    hc_nxt = vid.hcount + 11'd1;
    vc_nxt = vid.vcount;
    if (vid.hcount == 11'(H_TOTAL - 1)) begin
      hc_nxt = '0;
      if (vid.vcount == 11'(V_TOTAL - 1)) begin
        vc_nxt = '0;
      end else begin
        vc_nxt = vid.vcount + 11'd1;
      end
    end
  end

  // flags are decoded from the next position so they line up with the counts
  always_ff @(posedge clk) begin
    if (rst) begin
      vid         <= '0;
      frame_start <= 1'b0;
    end else begin
      vid.hcount  <= hc_nxt;
      vid.vcount  <= vc_nxt;
      vid.hblnk   <= (hc_nxt >= 11'(H_ACTIVE));
      vid.vblnk   <= (vc_nxt >= 11'(V_ACTIVE));
      vid.hsync   <= (hc_nxt >= 11'(H_SYNC_START)) && (hc_nxt < 11'(H_SYNC_END));
      vid.vsync   <= (vc_nxt >= 11'(V_SYNC_START)) && (vc_nxt < 11'(V_SYNC_END));
      // colour is added by the drawing stages
      vid.rgb     <= '0;
      frame_start <= (hc_nxt == '0) && (vc_nxt == '0);
    end
  end

endmodule

/* verilog/scene_pkg.sv */
// video stream struct, AXI4-Lite structs, ball config, colours, goal geometry, register map
package scene_pkg;

  // 4 bits per channel, r in the top nibble
  typedef logic [11:0] rgb_t;

  // one pixel step through the video pipeline
  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;
    logic        vsync;
    logic        hblnk;
    logic        vblnk;
    rgb_t        rgb;
  } vid_t;

  // host to slave
  typedef struct packed {
    logic        awvalid;
    logic [3:0]  awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [3:0]  araddr;
    logic        rready;
  } axil_req_t;

  // slave to host
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    logic [1:0]  rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic [10:0] x;
    logic [10:0] y;
    rgb_t        colour;
    logic        enable;
  } ball_cfg_t;

  // scene palette
  localparam rgb_t BLUE_BG       = 12'h4_A_F;
  localparam rgb_t GREEN_GRASS   = 12'h3_A_3;
  localparam rgb_t WHITE_LINES   = 12'hF_F_F;
  localparam rgb_t WHITE_NET     = 12'hE_E_E;
  localparam rgb_t GREY_GOALPOST = 12'hC_C_C;

  // goal seen from the keeper, in pixels
  localparam logic [10:0] GK_POST_OUTER_EDGE      = 11'd150;
  localparam logic [10:0] GK_POST_INNER_EDGE      = 11'd162;
  localparam logic [10:0] GK_POST_TOP_EDGE        = 11'd200;
  localparam logic [10:0] GK_CROSSBAR_BOTTOM_EDGE = 11'd212;
  localparam logic [10:0] GK_POST_BOTTOM_EDGE     = 11'd400;
  localparam logic [10:0] GK_NET_WIDTH            = 11'd20;
  localparam logic [10:0] GK_SIX_YARD_LINE        = 11'd330;
  localparam logic [10:0] GK_GRASS_HEIGHT         = 11'd300;
  localparam logic [10:0] PENALTY_SPOT_Y          = 11'd450;

  // square ball edge
  localparam logic [10:0] BALL_SIZE = 11'd16;

  // register map, byte offsets
  localparam logic [3:0] REG_POS   = 4'h0;
  localparam logic [3:0] REG_COLOR = 4'h4;
  localparam logic [3:0] REG_CTRL  = 4'h8;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage
